// File: hw/frontend_pkg.sv
package frontend_pkg;

    // Instruction address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // Block length in instructions for FETCH_WIDTH up to 8
    typedef logic [3:0] len_t;

    // One fetch block as produced by the predictor and held in the FTQ
    typedef struct packed {
        logic  valid;
        addr_t start_pc;
        len_t  length;
    } fetch_block_t;

    // One fetched instruction on its way to the backend
    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  last;     // final instruction of its block
    } fetched_inst_t;

    // Fetch unit FSM
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        DRAIN
    } fetch_state_e;

endpackage

// File: hw/block_predictor.sv
`timescale 1ns/1ps

module block_predictor #(
    parameter int                  FETCH_WIDTH = 4,
    parameter frontend_pkg::addr_t RESET_PC    = 32'h0000_1000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_i,
    input  frontend_pkg::addr_t        redirect_pc_i,
    input  logic                       queue_full_i,
    output frontend_pkg::fetch_block_t blk_o
);

    // Bytes covered by one block
    localparam frontend_pkg::addr_t BLOCK_BYTES = frontend_pkg::addr_t'(FETCH_WIDTH * 4);

    frontend_pkg::addr_t next_pc_q;
    logic                active_q;

    // Next block start follows the redirect PC after a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            next_pc_q <= RESET_PC;
            active_q  <= 1'b0;
        end else begin
            active_q <= 1'b1;
            if (flush_i) begin
                next_pc_q <= redirect_pc_i;
            end else if (blk_o.valid) begin
                next_pc_q <= next_pc_q + BLOCK_BYTES;
            end
        end
    end

    // Nothing is emitted in the flush cycle or while the FTQ is full
    always_comb begin
        blk_o.valid    = active_q && !flush_i && !queue_full_i;
        blk_o.start_pc = next_pc_q;
        blk_o.length   = frontend_pkg::len_t'(FETCH_WIDTH);
    end

    // Each written block is followed by the block right after it
    a_blocks_contiguous: assert property (
        @(posedge clk) disable iff (rst)
            blk_o.valid |=> blk_o.start_pc == $past(blk_o.start_pc) + BLOCK_BYTES
    );

endmodule

// File: hw/ftq.sv
`timescale 1ns/1ps

module ftq #(
    parameter int FTQ_SIZE = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  logic [$clog2(FTQ_SIZE)-1:0] flush_ftq_id_i,
    input  frontend_pkg::fetch_block_t  blk_i,
    input  logic                        commit_i,
    input  logic                        accept_i,
    output logic                        queue_full_o,
    output frontend_pkg::fetch_block_t  head_o,
    output logic [$clog2(FTQ_SIZE)-1:0] head_id_o
);

    localparam int ID_W = $clog2(FTQ_SIZE);

    frontend_pkg::fetch_block_t [FTQ_SIZE-1:0] queue_q;
    frontend_pkg::fetch_block_t [FTQ_SIZE-1:0] queue_d;

    logic [ID_W-1:0] pred_ptr_q;
    logic [ID_W-1:0] fetch_ptr_q;
    logic [ID_W-1:0] commit_ptr_q;
    logic [ID_W-1:0] pred_ptr_inc;
    logic [ID_W-1:0] flush_ptr;

    // Wraps naturally at FTQ_SIZE
    assign pred_ptr_inc = pred_ptr_q + 1'b1;
    assign flush_ptr    = flush_ftq_id_i + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_ptr_q   <= '0;
            fetch_ptr_q  <= '0;
            commit_ptr_q <= '0;
        end else begin
            // Commits keep draining older blocks across a flush
            if (commit_i) begin
                commit_ptr_q <= commit_ptr_q + 1'b1;
            end
            if (flush_i) begin
                pred_ptr_q  <= flush_ptr;
                fetch_ptr_q <= flush_ptr;
            end else begin
                if (blk_i.valid) begin
                    pred_ptr_q <= pred_ptr_inc;
                end
                if (accept_i) begin
                    fetch_ptr_q <= fetch_ptr_q + 1'b1;
                end
            end
        end
    end

    // Flush wins over every slot update
    always_comb begin
        queue_d = queue_q;
        if (commit_i) begin
            queue_d[commit_ptr_q] = '0;
        end
        if (blk_i.valid) begin
            queue_d[pred_ptr_q] = blk_i;
        end
        if (flush_i) begin
            queue_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            queue_q <= '0;
        end else begin
            queue_q <= queue_d;
        end
    end

    assign head_o       = queue_q[fetch_ptr_q];
    assign head_id_o    = fetch_ptr_q;
    // One slot stays free so full and empty differ
    assign queue_full_o = (pred_ptr_inc == commit_ptr_q);

    a_accept_needs_block: assert property (
        @(posedge clk) disable iff (rst) accept_i |-> head_o.valid
    );

    a_no_commit_when_empty: assert property (
        @(posedge clk) disable iff (rst) commit_i |-> (commit_ptr_q != pred_ptr_q)
    );

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int FTQ_SIZE = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  frontend_pkg::fetch_block_t  head_i,
    input  logic [$clog2(FTQ_SIZE)-1:0] head_id_i,
    input  logic                        ib_full_i,
    input  frontend_pkg::inst_t         wb_dat_i,
    input  logic                        wb_ack_i,
    output logic                        accept_o,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output frontend_pkg::addr_t         wb_adr_o,
    output logic                        push_valid_o,
    output frontend_pkg::fetched_inst_t push_o,
    output logic [$clog2(FTQ_SIZE)-1:0] push_id_o
);

    localparam int ID_W = $clog2(FTQ_SIZE);

    frontend_pkg::fetch_state_e state_q;
    frontend_pkg::addr_t        pc_q;
    frontend_pkg::len_t         remain_q;
    logic [ID_W-1:0]            id_q;
    logic                       stb_q;
    logic                       ack_done;
    logic                       last_inst;

    assign accept_o  = (state_q == frontend_pkg::IDLE) && head_i.valid && !flush_i;
    assign ack_done  = stb_q && wb_ack_i;
    assign last_inst = (remain_q == frontend_pkg::len_t'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= frontend_pkg::IDLE;
            stb_q   <= 1'b0;
        end else begin
            case (state_q)
                frontend_pkg::IDLE: begin
                    if (accept_o) begin
                        state_q <= frontend_pkg::REQ;
                    end
                end
                frontend_pkg::REQ: begin
                    if (flush_i) begin
                        // A read in flight must still see its ack
                        if (stb_q && !wb_ack_i) begin
                            state_q <= frontend_pkg::DRAIN;
                        end else begin
                            state_q <= frontend_pkg::IDLE;
                            stb_q   <= 1'b0;
                        end
                    end else if (ack_done) begin
                        stb_q <= 1'b0;
                        if (last_inst) begin
                            state_q <= frontend_pkg::IDLE;
                        end
                    end else if (!stb_q && !ib_full_i) begin
                        stb_q <= 1'b1;
                    end
                end
                frontend_pkg::DRAIN: begin
                    if (ack_done) begin
                        stb_q   <= 1'b0;
                        state_q <= frontend_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= frontend_pkg::IDLE;
                    stb_q   <= 1'b0;
                end
            endcase
        end
    end

    // Block payload walks one word per ack
    always_ff @(posedge clk) begin
        if (accept_o) begin
            pc_q     <= head_i.start_pc;
            remain_q <= head_i.length;
            id_q     <= head_id_i;
        end else if (state_q == frontend_pkg::REQ && ack_done) begin
            pc_q     <= pc_q + 32'd4;
            remain_q <= remain_q - 1'b1;
        end
    end

    assign wb_cyc_o = stb_q;
    assign wb_stb_o = stb_q;
    assign wb_we_o  = 1'b0;
    assign wb_adr_o = pc_q;

    // Data returned during a flush or a drain is dropped
    assign push_valid_o = (state_q == frontend_pkg::REQ) && ack_done && !flush_i;
    assign push_o.pc    = pc_q;
    assign push_o.inst  = wb_dat_i;
    assign push_o.last  = last_inst;
    assign push_id_o    = id_q;

    a_stb_held_until_ack: assert property (
        @(posedge clk) disable iff (rst) (wb_stb_o && !wb_ack_i) |=> wb_stb_o
    );

endmodule

// File: hw/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer #(
    parameter int IB_DEPTH = 4,
    parameter int FTQ_SIZE = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  logic                        push_valid_i,
    input  frontend_pkg::fetched_inst_t push_i,
    input  logic [$clog2(FTQ_SIZE)-1:0] push_id_i,
    input  logic                        ready_i,
    output logic                        full_o,
    output logic                        valid_o,
    output frontend_pkg::fetched_inst_t inst_o,
    output logic [$clog2(FTQ_SIZE)-1:0] id_o
);

    localparam int AW   = $clog2(IB_DEPTH);
    localparam int ID_W = $clog2(FTQ_SIZE);

    // Instruction and its FTQ id stored side by side
    typedef struct packed {
        frontend_pkg::fetched_inst_t inst;
        logic [ID_W-1:0]             id;
    } entry_t;

    entry_t        mem [IB_DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_valid_i && !flush_i;
    assign do_pop  = valid_o && ready_i && !flush_i;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= '{inst: push_i, id: push_id_i};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (AW + 1)'(do_push) - (AW + 1)'(do_pop);
        end
    end

    assign full_o  = (count_q == (AW + 1)'(IB_DEPTH));
    assign valid_o = (count_q != '0);
    assign inst_o  = mem[rd_ptr_q].inst;
    assign id_o    = mem[rd_ptr_q].id;

    // Fetch unit only reads when there is room
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) push_valid_i |-> !full_o
    );

endmodule

// File: hw/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter int                  FTQ_SIZE    = 8,
    parameter int                  FETCH_WIDTH = 4,
    parameter int                  IB_DEPTH    = 4,
    parameter frontend_pkg::addr_t RESET_PC    = 32'h0000_1000
) (
    input  logic                        clk,
    input  logic                        rst,

    // Backend side
    output frontend_pkg::fetched_inst_t inst_o,
    output logic [$clog2(FTQ_SIZE)-1:0] inst_ftq_id_o,
    output logic                        inst_valid_o,
    input  logic                        inst_ready_i,
    input  logic                        commit_i,
    input  logic                        flush_i,
    input  logic [$clog2(FTQ_SIZE)-1:0] flush_ftq_id_i,
    input  frontend_pkg::addr_t         redirect_pc_i,

    // Wishbone master to instruction memory
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output frontend_pkg::addr_t         wb_adr_o,
    input  frontend_pkg::inst_t         wb_dat_i,
    input  logic                        wb_ack_i
);

    localparam int ID_W = $clog2(FTQ_SIZE);

    frontend_pkg::fetch_block_t  pred_blk;
    logic                        queue_full;
    frontend_pkg::fetch_block_t  head_blk;
    logic [ID_W-1:0]             head_id;
    logic                        head_accept;
    logic                        ib_full;
    logic                        push_valid;
    frontend_pkg::fetched_inst_t push_inst;
    logic [ID_W-1:0]             push_id;

    block_predictor #(
        .FETCH_WIDTH (FETCH_WIDTH),
        .RESET_PC    (RESET_PC)
    ) u_block_predictor (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .queue_full_i  (queue_full),
        .blk_o         (pred_blk)
    );

    ftq #(
        .FTQ_SIZE (FTQ_SIZE)
    ) u_ftq (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .flush_ftq_id_i (flush_ftq_id_i),
        .blk_i          (pred_blk),
        .commit_i       (commit_i),
        .accept_i       (head_accept),
        .queue_full_o   (queue_full),
        .head_o         (head_blk),
        .head_id_o      (head_id)
    );

    fetch_unit #(
        .FTQ_SIZE (FTQ_SIZE)
    ) u_fetch_unit (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .head_i       (head_blk),
        .head_id_i    (head_id),
        .ib_full_i    (ib_full),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .accept_o     (head_accept),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .push_valid_o (push_valid),
        .push_o       (push_inst),
        .push_id_o    (push_id)
    );

    inst_buffer #(
        .IB_DEPTH (IB_DEPTH),
        .FTQ_SIZE (FTQ_SIZE)
    ) u_inst_buffer (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .push_valid_i (push_valid),
        .push_i       (push_inst),
        .push_id_i    (push_id),
        .ready_i      (inst_ready_i),
        .full_o       (ib_full),
        .valid_o      (inst_valid_o),
        .inst_o       (inst_o),
        .id_o         (inst_ftq_id_o)
    );

endmodule

// File: sim/tb_wb_memory.sv
`timescale 1ns/1ps

module tb_wb_memory (
    input  logic                clk,
    input  logic                rst,
    input  logic                cyc_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  frontend_pkg::addr_t adr_i,
    input  logic [1:0]          delay_i,
    output frontend_pkg::inst_t dat_o,
    output logic                ack_o
);

    logic       busy_q;
    logic [1:0] wait_q;

    // Contents follow from the whole address
    assign dat_o = adr_i ^ 32'hA5A5_5A5A;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            wait_q <= 2'd0;
            ack_o  <= 1'b0;
        end else begin
            ack_o <= 1'b0;
            if (cyc_i && stb_i && !we_i && !ack_o) begin
                if (!busy_q) begin
                    // Wait states picked when the request is first seen
                    if (delay_i == 2'd0) begin
                        ack_o <= 1'b1;
                    end else begin
                        busy_q <= 1'b1;
                        wait_q <= delay_i;
                    end
                end else if (wait_q == 2'd1) begin
                    ack_o  <= 1'b1;
                    busy_q <= 1'b0;
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end else if (!cyc_i) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

// File: sim/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;

    localparam int                  FTQ_SIZE    = 8;
    localparam int                  FETCH_WIDTH = 4;
    localparam int                  IB_DEPTH    = 4;
    localparam frontend_pkg::addr_t RESET_PC    = 32'h0000_1000;
    localparam int                  ID_W        = $clog2(FTQ_SIZE);

    localparam logic [31:0]         DATA_KEY    = 32'hA5A5_5A5A;
    localparam frontend_pkg::addr_t REDIRECT_A  = 32'h0000_4000;
    localparam frontend_pkg::addr_t REDIRECT_B  = 32'h0000_2008;

    // Stimulus points counted in delivered instructions
    localparam int NUM_INSTS   = 120;
    localparam int FLUSH_AT_A  = 10;
    localparam int FLUSH_AT_B  = 37;
    localparam int HOLD_AT     = 60;
    localparam int HOLD_CYCLES = 300;
    localparam int COMMIT_LAG  = 3;
    // 120 instructions at up to 8 cycles each plus the hold window is about 1300
    localparam int MAX_CYCLES  = 4000;

    logic                        clk;
    logic                        rst;
    frontend_pkg::fetched_inst_t inst;
    logic [ID_W-1:0]             inst_id;
    logic                        inst_valid;
    logic                        inst_ready;
    logic                        commit;
    logic                        flush;
    logic [ID_W-1:0]             flush_ftq_id;
    frontend_pkg::addr_t         redirect_pc;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    frontend_pkg::addr_t         wb_adr;
    frontend_pkg::inst_t         wb_dat;
    logic                        wb_ack;
    logic [1:0]                  mem_delay;

    // Backend model state
    logic [31:0]         rnd;
    int                  cycle = 0;
    int                  n_xfer;
    int                  blk_idx;
    int                  outstanding;
    int                  max_outstanding;
    int                  hold_start;
    int                  commit_at[$];
    logic                first_q;
    logic                after_flush;
    logic                took_inst;
    frontend_pkg::addr_t prev_pc;
    logic [ID_W-1:0]     prev_id;

    frontend_pkg::addr_t exp_pc;
    logic [ID_W-1:0]     exp_id;
    logic                exp_last;
    logic                xfer;

    frontend_top #(
        .FTQ_SIZE    (FTQ_SIZE),
        .FETCH_WIDTH (FETCH_WIDTH),
        .IB_DEPTH    (IB_DEPTH),
        .RESET_PC    (RESET_PC)
    ) dut (
        .clk            (clk),
        .rst            (rst),
        .inst_o         (inst),
        .inst_ftq_id_o  (inst_id),
        .inst_valid_o   (inst_valid),
        .inst_ready_i   (inst_ready),
        .commit_i       (commit),
        .flush_i        (flush),
        .flush_ftq_id_i (flush_ftq_id),
        .redirect_pc_i  (redirect_pc),
        .wb_cyc_o       (wb_cyc),
        .wb_stb_o       (wb_stb),
        .wb_we_o        (wb_we),
        .wb_adr_o       (wb_adr),
        .wb_dat_i       (wb_dat),
        .wb_ack_i       (wb_ack)
    );

    tb_wb_memory u_memory (
        .clk     (clk),
        .rst     (rst),
        .cyc_i   (wb_cyc),
        .stb_i   (wb_stb),
        .we_i    (wb_we),
        .adr_i   (wb_adr),
        .delay_i (mem_delay),
        .dat_o   (wb_dat),
        .ack_o   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        stop_with_failure();
    endtask

    // Next delivered instruction as the fetch rules predict it
    always_comb begin
        if (first_q) begin
            exp_pc = RESET_PC;
            exp_id = '0;
        end else if (after_flush) begin
            exp_pc = redirect_pc;
            exp_id = flush_ftq_id + ID_W'(1);
        end else begin
            exp_pc = prev_pc + 32'd4;
            exp_id = (blk_idx == 0) ? prev_id + ID_W'(1) : prev_id;
        end
        exp_last = (blk_idx == FETCH_WIDTH - 1);
    end

    assign xfer = inst_valid && inst_ready && !flush;

    a_data: assert property (@(posedge clk) disable iff (rst)
        xfer |-> inst.inst == (inst.pc ^ DATA_KEY))
        else report_mismatch("inst_o.inst", $sampled(inst.inst), $sampled(inst.pc) ^ DATA_KEY);

    // Covers the sequential rule and the redirect target alike
    a_pc: assert property (@(posedge clk) disable iff (rst)
        xfer |-> inst.pc == exp_pc)
        else report_mismatch("inst_o.pc", $sampled(inst.pc), $sampled(exp_pc));

    a_last: assert property (@(posedge clk) disable iff (rst)
        xfer |-> inst.last == exp_last)
        else report_mismatch("inst_o.last", 32'($sampled(inst.last)), 32'($sampled(exp_last)));

    a_id: assert property (@(posedge clk) disable iff (rst)
        xfer |-> inst_id == exp_id)
        else report_mismatch("inst_ftq_id_o", 32'($sampled(inst_id)), 32'($sampled(exp_id)));

    a_ftq_bound: assert property (@(posedge clk) disable iff (rst)
        outstanding <= FTQ_SIZE - 1)
        else begin
            $display("more than %0d blocks were delivered without a commit", FTQ_SIZE - 1);
            stop_with_failure();
        end

    // Read-only master, strobe only inside a cycle
    a_wb_read_only: assert property (@(posedge clk) disable iff (rst)
        !wb_we && (!wb_stb || wb_cyc))
        else begin
            $display("the Wishbone master wrote or raised strobe outside a bus cycle");
            stop_with_failure();
        end

    // Runs on each falling edge
    task automatic step_backend();
        frontend_pkg::addr_t cur_pc;
        logic [ID_W-1:0]     cur_id;
        logic                was_last;
        logic                holding;
        cur_pc   = exp_pc;
        cur_id   = exp_id;
        was_last = exp_last;
        flush    = 1'b0;
        commit   = 1'b0;
        if (took_inst) begin
            if (blk_idx == 0) begin
                outstanding = outstanding + 1;
            end
            n_xfer      = n_xfer + 1;
            first_q     = 1'b0;
            after_flush = 1'b0;
            prev_pc     = cur_pc;
            prev_id     = cur_id;
            blk_idx     = was_last ? 0 : blk_idx + 1;
            if (was_last) begin
                commit_at.push_back(cycle + COMMIT_LAG);
            end
            if (n_xfer == FLUSH_AT_A || n_xfer == FLUSH_AT_B) begin
                // Redirecting block ends here and is committed like any other
                flush        = 1'b1;
                flush_ftq_id = cur_id;
                redirect_pc  = (n_xfer == FLUSH_AT_A) ? REDIRECT_A : REDIRECT_B;
                after_flush  = 1'b1;
                blk_idx      = 0;
                if (!was_last) begin
                    commit_at.push_back(cycle + COMMIT_LAG);
                end
            end
            if (n_xfer == HOLD_AT) begin
                hold_start = cycle;
            end
        end
        holding = (hold_start >= 0) && (cycle < hold_start + HOLD_CYCLES);
        if (!holding && commit_at.size() > 0 && commit_at[0] <= cycle) begin
            commit = 1'b1;
            void'(commit_at.pop_front());
            outstanding = outstanding - 1;
        end
        if (outstanding > max_outstanding) begin
            max_outstanding = outstanding;
        end
        rnd        = xorshift32(rnd);
        inst_ready = (rnd[1:0] != 2'b00);
        mem_delay  = rnd[3:2];
        took_inst  = inst_valid && inst_ready && !flush;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    initial begin
        rst             = 1'b1;
        inst_ready      = 1'b0;
        commit          = 1'b0;
        flush           = 1'b0;
        flush_ftq_id    = '0;
        redirect_pc     = '0;
        mem_delay       = 2'd0;
        rnd             = 32'h898;
        n_xfer          = 0;
        blk_idx         = 0;
        outstanding     = 0;
        max_outstanding = 0;
        hold_start      = -1;
        first_q         = 1'b1;
        after_flush     = 1'b0;
        took_inst       = 1'b0;
        prev_pc         = '0;
        prev_id         = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (n_xfer < NUM_INSTS || commit_at.size() != 0) begin
            @(negedge clk);
            step_backend();
        end
        if (max_outstanding != FTQ_SIZE - 1) begin
            $display("the FTQ never filled while commits were held, peak was %0d blocks",
                     max_outstanding);
            stop_with_failure();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: frontend.f
hw/frontend_pkg.sv
hw/block_predictor.sv
hw/ftq.sv
hw/fetch_unit.sv
hw/inst_buffer.sv
hw/frontend_top.sv
sim/tb_wb_memory.sv
sim/tb_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frontend -f frontend.f -o tb_frontend
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
